// File: verilog/dna_pkg.sv
`default_nettype none

package dna_pkg;

  // identifier and cell geometry
  localparam int DNA_BITS   = 57;         // device identifier width
  localparam int CELL_BITS  = 64;         // shift cell / assembly width
  localparam int SHIFT_LAST = 64;         // last shift count, 65 samples per read

  typedef logic [DNA_BITS-1:0] dna_id_t;  // raw identifier

  // read sequencer states
  typedef enum logic {
    SEQ_IDLE  = 1'b0,                     // done high, cell held in load
    SEQ_SHIFT = 1'b1                      // read in progress
  } dna_seq_state_e;

  // local bus register map, read only
  typedef enum logic [1:0] {
    REG_ID_HI  = 2'd0,                    // zero padded upper 25 bits
    REG_ID_LO  = 2'd1,                    // lower 32 bits
    REG_STATUS = 2'd2                     // valid and read count
  } lb_addr_e;

  // word carried from dna_clk into lb_clk
  typedef struct packed {
    dna_id_t    id;                       // captured identifier
    logic [7:0] seq_count;                // completed reads, wraps
  } dna_xfer_t;

endpackage

`default_nettype wire

// File: verilog/dna_id_cell.sv
`timescale 1ns/1ps
`default_nettype none

// Behavioral stand-in for the device ID primitive. Loads the identifier
// left-aligned, then shifts it out MSB first.
module dna_id_cell #(
  parameter dna_pkg::dna_id_t ID_VALUE = 57'h000006789998212
) (
  input  logic dna_clk,
  input  logic read,                     // load, wins over shift
  input  logic shift,                    // shift enable
  input  logic din,                      // serial in at the low end
  output logic dout                      // serial out, top bit
);
  import dna_pkg::*;

  localparam int PAD_BITS = CELL_BITS - DNA_BITS;  // zero fill below the id

  // identifier sits in the top bits, zeros underneath
  localparam logic [CELL_BITS-1:0] CELL_IMAGE = {ID_VALUE, {PAD_BITS{1'b0}}};

  logic [CELL_BITS-1:0] cell_q;          // shift register contents

  always_ff @(posedge dna_clk) begin
    if (read) begin
      cell_q <= CELL_IMAGE;              // reload every cycle read is held
    end else if (shift) begin
      cell_q <= {cell_q[CELL_BITS-2:0], din};  // msb first, din refills
    end
  end

  assign dout = cell_q[CELL_BITS-1];     // current msb

endmodule

`default_nettype wire

// File: verilog/dna_read_seq.sv
`timescale 1ns/1ps
`default_nettype none

module dna_read_seq (
  input  logic               dna_clk,
  input  logic               rst,
  input  logic               start,      // level, rising edge starts a read
  input  logic               cell_dout,  // serial data from the cell
  output logic               cell_read,  // cell load
  output logic               cell_shift, // cell shift enable
  output logic               done,       // high when idle
  output logic               xfer_gate,  // one cycle, xfer is valid
  output dna_pkg::dna_xfer_t xfer        // identifier and read count
);
  import dna_pkg::*;

  localparam logic [6:0] LAST_CNT = 7'(SHIFT_LAST);  // count of the final sample

  dna_seq_state_e       state_q;         // idle / shifting
  logic                 start_s0;        // first start flop
  logic                 start_s1;        // second start flop
  logic                 start_rise;      // edge seen this cycle
  logic [6:0]           shift_cnt;       // 0..64 within a read
  logic                 last_shift;      // final sample this cycle
  logic [CELL_BITS-1:0] asm_q;           // sample assembly
  logic [CELL_BITS-1:0] asm_next;        // assembly with this cycle's bit
  dna_id_t              id_q;            // published identifier
  logic [7:0]           seq_count;       // completed reads

  assign start_rise = start_s0 & ~start_s1;
  assign last_shift = (state_q == SEQ_SHIFT) && (shift_cnt == LAST_CNT);
  assign asm_next   = {asm_q[CELL_BITS-2:0], cell_dout};  // new bit in at lsb

  assign cell_read  = (shift_cnt == 7'd0);  // includes all of idle
  assign done       = (state_q == SEQ_IDLE);

  assign xfer = '{id: id_q, seq_count: seq_count};

  // control path
  always_ff @(posedge dna_clk) begin
    if (rst) begin
      state_q    <= SEQ_IDLE;            // done high after reset
      start_s0   <= 1'b0;
      start_s1   <= 1'b0;
      shift_cnt  <= 7'd0;
      cell_shift <= 1'b0;
      xfer_gate  <= 1'b0;                // aborted read never publishes
      seq_count  <= 8'd0;
    end else begin
      start_s0  <= start;
      start_s1  <= start_s0;
      xfer_gate <= 1'b0;                 // pulse default
      case (state_q)
        SEQ_IDLE: begin
          cell_shift <= 1'b0;
          if (start_rise) begin
            state_q <= SEQ_SHIFT;        // done falls here
          end
        end
        SEQ_SHIFT: begin
          cell_shift <= 1'b1;            // high after the first read cycle
          if (shift_cnt == LAST_CNT) begin
            state_q   <= SEQ_IDLE;       // done rises
            shift_cnt <= 7'd0;
            xfer_gate <= 1'b1;
            seq_count <= seq_count + 8'd1;
          end else begin
            shift_cnt <= shift_cnt + 7'd1;
          end
        end
        default: begin
          state_q <= SEQ_IDLE;
        end
      endcase
    end
  end

  // data path
  always_ff @(posedge dna_clk) begin
    if (state_q == SEQ_SHIFT) begin
      asm_q <= asm_next;                 // one sample per read cycle
    end
    if (last_shift) begin
      // first two samples repeat bit 63, so 63:7 is the identifier
      id_q <= asm_next[CELL_BITS-1 -: DNA_BITS];
    end
  end

endmodule

`default_nettype wire

// File: verilog/data_xdomain.sv
`timescale 1ns/1ps
`default_nettype none

// Toggle crossing for a gated word. The source holds the word and flips a
// toggle on each gate, the destination pulses gate_out when the flip lands.
// A new gate must wait until the previous one has crossed.
module data_xdomain #(
  parameter int XFER_BITS = 8
) (
  input  logic                 clk_in,   // source clock
  input  logic                 gate_in,  // one cycle, data_in valid
  input  logic [XFER_BITS-1:0] data_in,
  input  logic                 clk_out,  // destination clock
  output logic                 gate_out, // one cycle in clk_out
  output logic [XFER_BITS-1:0] data_out  // held word, stable at gate_out
);

  logic [XFER_BITS-1:0] hold_q;          // word latched in clk_in
  logic                 tog_in = 1'b0;   // flips once per gate
  logic [2:0]           tog_sync = 3'b000; // destination synchronizer
  logic                 gate_q = 1'b0;   // registered edge detect

  // source side
  always_ff @(posedge clk_in) begin
    if (gate_in) begin
      hold_q <= data_in;                 // captured with the toggle
      tog_in <= ~tog_in;
    end
  end

  // destination side
  always_ff @(posedge clk_out) begin
    tog_sync <= {tog_sync[1:0], tog_in}; // [0] may go metastable
    gate_q   <= tog_sync[2] ^ tog_sync[1]; // last two differ on arrival
  end

  assign gate_out = gate_q;
  assign data_out = hold_q;              // quiet long before gate_out

endmodule

`default_nettype wire

// File: verilog/dna_lb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module dna_lb_regs (
  input  logic               lb_clk,
  input  logic               rst,        // dna_clk domain reset
  input  logic               gate,       // crossed word valid
  input  dna_pkg::dna_xfer_t xfer,
  input  dna_pkg::lb_addr_e  lb_addr,
  output logic [31:0]        lb_rdata    // one lb_clk after lb_addr
);
  import dna_pkg::*;

  logic       rst_s0;                    // reset synchronizer, stage 1
  logic       rst_s1;                    // reset synchronizer, stage 2
  logic       lb_rst;                    // local reset
  logic [2:0] holdoff;                   // gates ignored while nonzero
  logic       accept;                    // capture this cycle
  dna_id_t    id_q;                      // captured identifier
  logic [7:0] count_q;                   // captured read count
  logic       valid_q;                   // at least one capture

  assign lb_rst = rst_s1;
  assign accept = gate && (holdoff == 3'd0);

  always_ff @(posedge lb_clk) begin
    rst_s0 <= rst;
    rst_s1 <= rst_s0;
  end

  // mask stale toggles for four cycles after reset release
  always_ff @(posedge lb_clk) begin
    if (lb_rst) begin
      holdoff <= 3'd4;
    end else if (holdoff != 3'd0) begin
      holdoff <= holdoff - 3'd1;
    end
  end

  // capture
  always_ff @(posedge lb_clk) begin
    if (lb_rst) begin
      id_q    <= '0;
      count_q <= 8'd0;
      valid_q <= 1'b0;
    end else if (accept) begin
      id_q    <= xfer.id;
      count_q <= xfer.seq_count;
      valid_q <= 1'b1;                   // sticky until reset
    end
  end

  // registered read mux
  always_ff @(posedge lb_clk) begin
    if (lb_rst) begin
      lb_rdata <= 32'd0;
    end else begin
      case (lb_addr)
        REG_ID_HI:  lb_rdata <= {7'd0, id_q[DNA_BITS-1:32]};  // bits 56:32
        REG_ID_LO:  lb_rdata <= id_q[31:0];
        REG_STATUS: lb_rdata <= {16'd0, count_q, 7'd0, valid_q};
        default:    lb_rdata <= 32'd0;   // unmapped reads zero
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/dna_top.sv
`timescale 1ns/1ps
`default_nettype none

module dna_top #(
  parameter dna_pkg::dna_id_t ID_VALUE = 57'h000006789998212
) (
  input  logic              dna_clk,
  input  logic              lb_clk,
  input  logic              rst,         // sync to dna_clk, active high
  input  logic              start,
  output logic              done,
  input  dna_pkg::lb_addr_e lb_addr,
  output logic [31:0]       lb_rdata
);
  import dna_pkg::*;

  localparam int XFER_BITS = $bits(dna_xfer_t);  // crossing width

  logic      cell_read;                  // sequencer -> cell
  logic      cell_shift;
  logic      cell_dout;                  // cell -> sequencer
  logic      cell_din;                   // loop-back into the cell
  logic      xfer_gate;                  // dna_clk gate
  dna_xfer_t xfer_src;                   // dna_clk side word
  logic      lb_gate;                    // lb_clk gate
  dna_xfer_t xfer_lb;                    // lb_clk side word

  assign cell_din = cell_dout;           // cell refills with its own output

  dna_id_cell #(
    .ID_VALUE (ID_VALUE)
  ) dna_id_cell_inst (
    .dna_clk (dna_clk),
    .read    (cell_read),
    .shift   (cell_shift),
    .din     (cell_din),
    .dout    (cell_dout)
  );

  dna_read_seq dna_read_seq_inst (
    .dna_clk    (dna_clk),
    .rst        (rst),
    .start      (start),
    .cell_dout  (cell_dout),
    .cell_read  (cell_read),
    .cell_shift (cell_shift),
    .done       (done),
    .xfer_gate  (xfer_gate),
    .xfer       (xfer_src)
  );

  data_xdomain #(
    .XFER_BITS (XFER_BITS)
  ) data_xdomain_inst (
    .clk_in   (dna_clk),
    .gate_in  (xfer_gate),
    .data_in  (xfer_src),
    .clk_out  (lb_clk),
    .gate_out (lb_gate),
    .data_out (xfer_lb)
  );

  dna_lb_regs dna_lb_regs_inst (
    .lb_clk   (lb_clk),
    .rst      (rst),
    .gate     (lb_gate),
    .xfer     (xfer_lb),
    .lb_addr  (lb_addr),
    .lb_rdata (lb_rdata)
  );

endmodule

`default_nettype wire

// File: tests/dna_top_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dna_top_tb;
  import dna_pkg::*;

  localparam dna_id_t ID_VALUE     = 57'h000006789998212;  // same as the id line of the list
  localparam string   LIST_PATH    = "tests/dna_testdata.txt";
  localparam int      CYC_PER_TEST = 300;                  // dna_clk budget per test
  localparam int      FALL_EDGES   = 2;                    // start drive edge to done low
  localparam int      READ_LOW     = 65;                   // done low cycles, one per sample
  localparam int      QUIET_CYC    = 10;                   // idle watch after a read
  localparam int      BUSY_AT      = 20;                   // stray start inside a read

  logic        dna_clk = 1'b0;
  logic        lb_clk  = 1'b0;
  logic        rst;
  logic        start;
  logic        done;
  lb_addr_e    lb_addr;
  logic [31:0] lb_rdata;

  string       test_names[$];                // per test, from the list
  string       test_cmds[$];
  int          test_counts[$];               // expected status count
  dna_id_t     file_id;                      // identifier from the list
  bit          setup_bad   = 1'b0;           // list missing or inconsistent
  int          cycle_count = 0;
  int          cycle_limit = 0;              // zero until the list is read
  int          test_errs   = 0;              // mismatches in the running test
  int          n_pass      = 0;
  int          n_fail      = 0;

  dna_top #(
    .ID_VALUE (ID_VALUE)
  ) dna_top_inst (
    .dna_clk  (dna_clk),
    .lb_clk   (lb_clk),
    .rst      (rst),
    .start    (start),
    .done     (done),
    .lb_addr  (lb_addr),
    .lb_rdata (lb_rdata)
  );

  always #2 dna_clk = ~dna_clk;              // 4 ns
  always #3 lb_clk  = ~lb_clk;               // 6 ns, unrelated to dna_clk

  // run length guard
  always @(posedge dna_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("timeout: run still busy after %0d dna_clk cycles", cycle_limit);
      $display("test failed");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input string what,
                                 input logic [63:0] exp, input logic [63:0] act);
    $display("CHECK FAILED %0s %0s: expected %0h, actual %0h", name, what, exp, act);
    test_errs++;
  endtask

  // address on one edge, registered data one edge later
  task automatic bus_read(input lb_addr_e addr, output logic [31:0] data);
    @(posedge lb_clk);
    lb_addr <= addr;
    @(posedge lb_clk);
    @(negedge lb_clk);                       // rdata stable here
    data = lb_rdata;
  endtask

  task automatic load_test_list();
    int      fd;
    int      n;
    int      cnt;
    bit      have_id;
    string   line;
    string   tok;
    string   nm;
    string   cm;
    dna_id_t val;
    have_id = 1'b0;
    fd = $fopen(LIST_PATH, "r");
    if (fd == 0) begin
      $display("cannot open the test list %0s", LIST_PATH);
      setup_bad = 1'b1;
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() == 0 || line.getc(0) == "#") begin
          continue;                          // comment or empty
        end
        if (!have_id) begin
          n = $sscanf(line, "%s %h", tok, val);
          if (n == 2 && tok == "id") begin
            file_id = val;
            have_id = 1'b1;
          end
        end else begin
          n = $sscanf(line, "%s %s %d", nm, cm, cnt);
          if (n == 3) begin
            test_names.push_back(nm);
            test_cmds.push_back(cm);
            test_counts.push_back(cnt);
          end
        end
      end
      $fclose(fd);
      if (!have_id) begin
        $display("the test list has no id line");
        setup_bad = 1'b1;
      end else if (file_id !== ID_VALUE) begin
        $display("identifier in the list (%0h) differs from the DUT parameter (%0h)",
                 file_id, ID_VALUE);
        setup_bad = 1'b1;
      end
    end
  endtask

  // five dna_clk edges with rst high, done must rise on the first
  task automatic pulse_reset(input string name);
    @(posedge dna_clk);
    rst <= 1'b1;
    @(posedge dna_clk);
    @(negedge dna_clk);
    if (done !== 1'b1) report_mismatch(name, "done in reset", 64'd1, 64'(done));
    repeat (4) @(posedge dna_clk);
    rst <= 1'b0;
  endtask

  // one read from a start edge, with edge and cycle counts sampled at negedge
  task automatic run_read(input bit hold, input int busy_at, output int fall_edges,
                          output int low_cycles, output int late_low);
    fall_edges = 0;
    low_cycles = 0;
    late_low   = 0;
    @(posedge dna_clk);
    start <= 1'b1;
    while (done === 1'b1 && fall_edges < 8) begin
      @(posedge dna_clk);
      fall_edges++;
      if (!hold) start <= 1'b0;              // one cycle pulse
      @(negedge dna_clk);
    end
    if (done === 1'b0) low_cycles = 1;
    while (done === 1'b0 && low_cycles < 4 * READ_LOW) begin
      @(posedge dna_clk);
      if (busy_at > 0 && low_cycles == busy_at) begin
        start <= 1'b1;                       // must be ignored
      end else if (!hold) begin
        start <= 1'b0;
      end
      @(negedge dna_clk);
      if (done === 1'b0) low_cycles++;
    end
    repeat (QUIET_CYC) begin
      @(negedge dna_clk);
      if (done !== 1'b1) late_low++;         // a second read would show here
    end
    @(posedge dna_clk);
    start <= 1'b0;
  endtask

  // poll status until the expected count shows up, bounded
  task automatic wait_capture(input logic [7:0] exp_count);
    logic [31:0] rd;
    int          tries;
    rd    = 32'd0;
    tries = 0;
    while (!(rd[0] === 1'b1 && rd[15:8] === exp_count) && tries < 40) begin
      bus_read(REG_STATUS, rd);
      tries++;
    end
  endtask

  task automatic verify_registers(input string name, input logic [7:0] exp_count,
                                  input logic exp_valid);
    logic [31:0] rd;
    logic [31:0] exp_hi;
    logic [31:0] exp_lo;
    logic [31:0] exp_st;
    exp_hi = exp_valid ? {7'd0, file_id[DNA_BITS-1:32]} : 32'd0;  // zeros when empty
    exp_lo = exp_valid ? file_id[31:0] : 32'd0;
    exp_st = {16'd0, exp_count, 7'd0, exp_valid};
    bus_read(REG_STATUS, rd);
    if (rd !== exp_st) report_mismatch(name, "status", 64'(exp_st), 64'(rd));
    bus_read(REG_ID_HI, rd);
    if (rd !== exp_hi) report_mismatch(name, "id_hi", 64'(exp_hi), 64'(rd));
    bus_read(REG_ID_LO, rd);
    if (rd !== exp_lo) report_mismatch(name, "id_lo", 64'(exp_lo), 64'(rd));
  endtask

  initial begin
    int         seed;
    int         gap;
    int         fall_edges;
    int         low_cycles;
    int         late_low;
    logic [7:0] exp_count;
    string      name;
    string      cmd;
    rst     = 1'b1;                          // held until the first reset test
    start   = 1'b0;
    lb_addr = REG_STATUS;
    seed    = $urandom(32'hc5db);
    load_test_list();
    cycle_limit = test_names.size() * CYC_PER_TEST;
    for (int i = 0; i < test_names.size(); i++) begin
      name      = test_names[i];
      cmd       = test_cmds[i];
      exp_count = 8'(test_counts[i]);
      test_errs = 0;
      gap       = $urandom % 16;             // idle gap 0..15
      repeat (gap) @(posedge dna_clk);
      if (cmd == "reset") begin
        pulse_reset(name);
        repeat (16) @(posedge lb_clk);       // rst sync plus holdoff
        verify_registers(name, exp_count, 1'b0);
      end else if (cmd == "rst_mid") begin
        @(posedge dna_clk);
        start <= 1'b1;
        @(posedge dna_clk);
        start <= 1'b0;
        repeat (30) @(negedge dna_clk);      // well inside the shift phase
        if (done !== 1'b0) report_mismatch(name, "done before abort", 64'd0, 64'(done));
        pulse_reset(name);
        repeat (50) @(posedge lb_clk);       // past where the read would have ended
        verify_registers(name, exp_count, 1'b0);
      end else if (cmd == "start" || cmd == "start_hold" || cmd == "start_busy") begin
        run_read(cmd == "start_hold", (cmd == "start_busy") ? BUSY_AT : 0,
                 fall_edges, low_cycles, late_low);
        if (fall_edges != FALL_EDGES) begin
          report_mismatch(name, "edges to done fall", 64'(FALL_EDGES), 64'(fall_edges));
        end
        if (low_cycles != READ_LOW) begin
          report_mismatch(name, "done low cycles", 64'(READ_LOW), 64'(low_cycles));
        end
        if (late_low != 0) report_mismatch(name, "extra read cycles", 64'd0, 64'(late_low));
        wait_capture(exp_count);
        verify_registers(name, exp_count, 1'b1);
      end else begin
        $display("test %0s has an unknown command %0s", name, cmd);
        test_errs++;
      end
      if (test_errs == 0) begin
        n_pass++;
        $display("%0s (%0s): ok", name, cmd);
      end else begin
        n_fail++;
        $display("%0s (%0s): %0d mismatch(es)", name, cmd, test_errs);
      end
    end
    $display("summary: %0d ok, %0d with errors", n_pass, n_fail);
    if (n_fail == 0 && !setup_bad && test_names.size() != 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/dna_testdata.txt
# first data line: id <identifier, 57-bit hex>
# then one test per line: <name> <command> <expected status count>
id 000006789998212
power_on      reset       0
read_first    start       1
read_second   start       2
hold_high     start_hold  3
busy_pulse    start_busy  4
read_after    start       5
abort_mid     rst_mid     0
read_again    start       1
reset_again   reset       0
read_fresh    start       1
hold_fresh    start_hold  2
busy_fresh    start_busy  3
read_last     start       4

// File: dna_reader.f
verilog/dna_pkg.sv
verilog/dna_id_cell.sv
verilog/dna_read_seq.sv
verilog/data_xdomain.sv
verilog/dna_lb_regs.sv
verilog/dna_top.sv
tests/dna_top_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the dna_reader testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=dna_top_tb_sim
log=sim.log

verilator --binary --timing --top-module dna_top_tb \
  -f dna_reader.f -Mdir "$build_dir" -o "$sim_bin"
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$build_dir/$sim_bin" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" "$log"; then
  exit 0
fi
echo "pass line not found in $log"
exit 1
